// ==== Makefile ====
# Verilator build and run of the serial link testbench

VERILATOR       ?= verilator
TOP             ?= tb_serial_link
FILELIST        ?= serial_link.f
OBJ_DIR         ?= obj_dir
VERILATOR_FLAGS ?= --binary --timing --assert -Wno-fatal
EXTRA_FLAGS     ?=

.PHONY: sim clean

# build, then run; a $fatal in the testbench gives a failing exit status
sim:
	$(VERILATOR) $(VERILATOR_FLAGS) $(EXTRA_FLAGS) --top-module $(TOP) \
		--Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// ==== serial_link.f ====
src/serial_link_pkg.sv
src/tx_queue.sv
src/par2ser.sv
src/ser2par.sv
src/serial_link.sv
testbench/tb_serial_link.sv

// ==== src/par2ser.sv ====
// parallel to serial converter
// loads a request into a shift register and sends 1..NL lanes on shift strobes,
// msb lane first or lsb lane first, a remote wait holds off new frames
`timescale 1ns/1ns
`default_nettype none

module par2ser (
   input  logic                      clk,
   input  logic                      nreset,
   input  serial_link_pkg::tx_req_t  req,
   input  logic                      load,
   input  logic                      shift,
   input  logic                      lsbfirst,
   input  logic                      wait_in,
   output logic                      start,
   output logic                      wait_out,
   output serial_link_pkg::ser_bus_t ser
);

   import serial_link_pkg::*;

   // lanes still to send, zero when idle
   size_t count;
   word_t shift_reg;
   logic  busy;
   logic  step;

   //##########################################################################
   // frame control
   //##########################################################################

   assign busy = (count != '0);

   // new frame only from an idle converter and no remote wait
   assign start = load & ~wait_in & ~busy;

   // a strobe outside a frame is ignored
   assign step = shift & busy;

   // far end sees us busy while a frame runs or it asked for a pause
   assign wait_out = wait_in | busy;

   // lane counter
   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset)
         count <= '0;
      else if (start)
         count <= req.size;
      else if (step)
         count <= count - 1'b1;
   end

   //##########################################################################
   // shift register
   //##########################################################################

   // lsb first moves toward the low end, msb first toward the high end
   // vacated lanes fill with zeros, they are never sampled
   always_ff @(posedge clk) begin
      if (start)
         shift_reg <= req.data;
      else if (step && lsbfirst)
         shift_reg <= {{SW{1'b0}}, shift_reg[PW-1:SW]};
      else if (step)
         shift_reg <= {shift_reg[PW-SW-1:0], {SW{1'b0}}};
   end

   //##########################################################################
   // serial bus
   //##########################################################################

   always_comb begin
      ser.valid = busy;
      ser.shift = step;
      // outgoing lane from the end that leaves first
      if (lsbfirst)
         ser.data = shift_reg[SW-1:0];
      else
         ser.data = shift_reg[PW-1:PW-SW];
   end

   //##########################################################################
   // checks
   //##########################################################################

   // a zero size would start nothing and the frame would never show
   a_size_nonzero: assert property (@(posedge clk) disable iff (!nreset)
      start |-> (req.size != '0))
      else $error("par2ser: frame started with size zero");

endmodule

`default_nettype wire

// ==== src/ser2par.sv ====
// serial to parallel collector
// rebuilds each word from the lanes on the serial bus and pulses word_valid
// one cycle after the frame ends
`timescale 1ns/1ns
`default_nettype none

module ser2par (
   input  logic                      clk,
   input  logic                      nreset,
   input  serial_link_pkg::ser_bus_t ser,
   input  logic                      lsbfirst,
   output logic                      word_valid,
   output serial_link_pkg::word_t    word
);

   import serial_link_pkg::*;

   // bits of a lane position inside the word
   localparam int LW = $clog2(NL);

   word_t asm_reg;
   word_t asm_next;
   // lanes collected so far in this frame
   size_t idx;
   size_t idx_next;
   logic  prev_valid;
   logic  take;
   logic  frame_begin;
   logic  frame_end;

   //##########################################################################
   // frame tracking
   //##########################################################################

   assign take        = ser.valid & ser.shift;
   assign frame_begin = ser.valid & ~prev_valid;
   // first idle cycle after a frame
   assign frame_end   = ~ser.valid & prev_valid;

   //##########################################################################
   // assembly
   //##########################################################################

   // first lane can arrive in the very first valid cycle,
   // so the clear and the insert are merged here
   always_comb begin
      asm_next = frame_begin ? '0 : asm_reg;
      idx_next = frame_begin ? '0 : idx;
      if (take) begin
         if (lsbfirst)
            // lane i lands at lane position i
            asm_next[idx_next[LW-1:0]*SW +: SW] = ser.data;
         else
            // shift in at the bottom, result right aligned
            asm_next = {asm_next[PW-SW-1:0], ser.data};
         idx_next = idx_next + 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      asm_reg <= asm_next;
   end

   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         prev_valid <= 1'b0;
         idx        <= '0;
         word_valid <= 1'b0;
      end
      else begin
         prev_valid <= ser.valid;
         idx        <= idx_next;
         // one strobe per frame, a cycle after valid drops
         word_valid <= frame_end;
      end
   end

   // output word held until the next frame ends
   always_ff @(posedge clk) begin
      if (frame_end)
         word <= asm_reg;
   end

   //##########################################################################
   // checks
   //##########################################################################

   // sender never runs a frame longer than a full word
   a_idx_range: assert property (@(posedge clk) disable iff (!nreset)
      idx <= size_t'(NL))
      else $error("ser2par: more than NL lanes in one frame");

endmodule

`default_nettype wire

// ==== src/serial_link.sv ====
// serial link top level
// transmit queue feeding the parallel to serial converter, plus the
// serial to parallel collector on the receive pins
`timescale 1ns/1ns
`default_nettype none

module serial_link #(
   parameter int QUEUE_DEPTH = 4
) (
   input  logic                      clk,
   input  logic                      nreset,
   // transmit requests
   input  logic                      tx_push,
   input  serial_link_pkg::tx_req_t  tx_req,
   output logic                      tx_full,
   // link control
   input  logic                      lsbfirst,
   input  logic                      shift_en,
   input  logic                      link_wait,
   output logic                      link_busy,
   // serial pins
   output serial_link_pkg::ser_bus_t ser_out,
   input  serial_link_pkg::ser_bus_t ser_in,
   // received words
   output logic                      rx_valid,
   output serial_link_pkg::word_t    rx_word
);

   import serial_link_pkg::*;

   // queue head and handshake to the converter
   tx_req_t head;
   logic    not_empty;
   logic    start;

   //##########################################################################
   // transmit side
   //##########################################################################

   // queue pops in the same cycle the converter starts a frame
   tx_queue #(
      .DEPTH     (QUEUE_DEPTH)
   ) tx_queue_i (
      .clk       (clk),
      .nreset    (nreset),
      .push      (tx_push),
      .push_req  (tx_req),
      .pop       (start),
      .head      (head),
      .not_empty (not_empty),
      .full      (tx_full)
   );

   par2ser par2ser_i (
      .clk       (clk),
      .nreset    (nreset),
      .req       (head),
      .load      (not_empty),
      .shift     (shift_en),
      .lsbfirst  (lsbfirst),
      .wait_in   (link_wait),
      .start     (start),
      .wait_out  (link_busy),
      .ser       (ser_out)
   );

   //##########################################################################
   // receive side
   //##########################################################################

   ser2par ser2par_i (
      .clk        (clk),
      .nreset     (nreset),
      .ser        (ser_in),
      .lsbfirst   (lsbfirst),
      .word_valid (rx_valid),
      .word       (rx_word)
   );

endmodule

`default_nettype wire

// ==== src/serial_link_pkg.sv ====
// serial link shared definitions
// word and lane widths, vector types and the structs passed between blocks
`default_nettype none

package serial_link_pkg;

   //##########################################################################
   // widths
   //##########################################################################

   // parallel word width
   localparam int PW = 32;
   // serial lane width
   localparam int SW = 2;
   // lanes per full word
   localparam int NL = PW / SW;
   // lane counter holds 0..NL, one bit wider than a lane index
   localparam int CW = $clog2(NL + 1);

   //##########################################################################
   // types
   //##########################################################################

   typedef logic [PW-1:0] word_t;
   typedef logic [SW-1:0] lane_t;
   // frame length in lanes, legal 1..NL
   typedef logic [CW-1:0] size_t;

   // one transmit request as it sits in the queue
   typedef struct packed {
      word_t data;
      size_t size;
   } tx_req_t;

   // serial link between transmitter and receiver
   typedef struct packed {
      logic  valid;
      logic  shift;
      lane_t data;
   } ser_bus_t;

endpackage

`default_nettype wire

// ==== src/tx_queue.sv ====
// transmit request queue
// small circular FIFO holding words waiting for the serializer,
// head request shown combinationally with a not-empty level
`timescale 1ns/1ns
`default_nettype none

module tx_queue #(
   parameter int DEPTH = 4
) (
   input  logic                      clk,
   input  logic                      nreset,
   input  logic                      push,
   input  serial_link_pkg::tx_req_t  push_req,
   input  logic                      pop,
   output serial_link_pkg::tx_req_t  head,
   output logic                      not_empty,
   output logic                      full
);

   import serial_link_pkg::*;

   // pointer and occupancy widths
   localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int NW = $clog2(DEPTH + 1);

   tx_req_t       mem [DEPTH];
   logic [AW-1:0] wr_ptr;
   logic [AW-1:0] rd_ptr;
   logic [NW-1:0] count;
   logic          push_ok;
   logic          pop_ok;

   // wrap at DEPTH, depth need not be a power of two
   function automatic logic [AW-1:0] next_ptr(input logic [AW-1:0] ptr);
      if (ptr == AW'(DEPTH - 1))
         return '0;
      return ptr + 1'b1;
   endfunction

   //##########################################################################
   // status
   //##########################################################################

   assign not_empty = (count != '0);
   assign full      = (count == NW'(DEPTH));

   // an illegal push or pop leaves the queue untouched
   assign push_ok = push & ~full;
   assign pop_ok  = pop & not_empty;

   //##########################################################################
   // storage
   //##########################################################################

   always_ff @(posedge clk) begin
      if (push_ok)
         mem[wr_ptr] <= push_req;
   end

   // oldest entry goes straight to the serializer
   assign head = mem[rd_ptr];

   // pointers and occupancy
   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else begin
         if (push_ok)
            wr_ptr <= next_ptr(wr_ptr);
         if (pop_ok)
            rd_ptr <= next_ptr(rd_ptr);
         // simultaneous push and pop keeps the count
         case ({push_ok, pop_ok})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   //##########################################################################
   // checks
   //##########################################################################

   // source must honour tx_full
   a_no_push_full: assert property (@(posedge clk) disable iff (!nreset)
      push |-> !full)
      else $error("tx_queue: push while full");

   // serializer only starts on a queued request
   a_no_pop_empty: assert property (@(posedge clk) disable iff (!nreset)
      pop |-> not_empty)
      else $error("tx_queue: pop while empty");

endmodule

`default_nettype wire

// ==== testbench/tb_serial_link.sv ====
// serial link testbench
// random loopback traffic from a fixed seed LFSR, checked against a model
// of the frame rules at the serial pins and at the receive port
`timescale 1ns/1ns
`default_nettype none

module tb_serial_link;

   import serial_link_pkg::*;

   //##########################################################################
   // timing and limits
   //##########################################################################

   localparam int CLK_PERIOD   = 8;
   localparam int QUEUE_DEPTH  = 4;
   // watchdog budget, well above the frames actually sent
   localparam int MAX_FRAMES   = 600;
   localparam int FRAME_CYCLES = 80;
   localparam int WATCHDOG_NS  = MAX_FRAMES * FRAME_CYCLES * CLK_PERIOD;
   localparam logic [31:0] LFSR_SEED = 32'hecf25088;
   // x^32 + x^22 + x^2 + x + 1 in right shifting form
   localparam logic [31:0] LFSR_TAPS = 32'h80200003;

   logic     clk;
   logic     nreset;
   logic     tx_push;
   tx_req_t  tx_req;
   logic     lsbfirst;
   logic     shift_en;
   logic     link_wait;
   logic     tx_full;
   logic     link_busy;
   // ser_out looped straight back to ser_in
   ser_bus_t ser_link;
   logic     rx_valid;
   word_t    rx_word;

   // reference model state
   word_t       exp_words[$];
   size_t       exp_sizes[$];
   logic [31:0] lfsr_state;
   int          to_push;
   int          phase_pushes;
   // valid-and-shift strobes seen in the current frame
   int          strobes;
   logic        prev_valid;
   logic        prev_wait;

   serial_link #(
      .QUEUE_DEPTH (QUEUE_DEPTH)
   ) serial_link_i (
      .clk       (clk),
      .nreset    (nreset),
      .tx_push   (tx_push),
      .tx_req    (tx_req),
      .tx_full   (tx_full),
      .lsbfirst  (lsbfirst),
      .shift_en  (shift_en),
      .link_wait (link_wait),
      .link_busy (link_busy),
      .ser_out   (ser_link),
      .ser_in    (ser_link),
      .rx_valid  (rx_valid),
      .rx_word   (rx_word)
   );

   always #(CLK_PERIOD / 2) clk = ~clk;

   //##########################################################################
   // random source and model
   //##########################################################################

   function automatic logic [31:0] lfsr_step(input logic [31:0] state);
      if (state[0])
         return (state >> 1) ^ LFSR_TAPS;
      return state >> 1;
   endfunction

   // one LFSR step per bit, bits collected msb first
   task automatic take_bits(input int n, output logic [31:0] bits);
      int i;
      bits = '0;
      for (i = 0; i < n; i++) begin
         lfsr_state = lfsr_step(lfsr_state);
         bits = {bits[30:0], lfsr_state[0]};
      end
   endtask

   // word the receiver should rebuild from one request
   function automatic word_t expected_word(input word_t data, input size_t size,
                                           input logic lsb);
      int    nbits;
      int    b;
      word_t mask;
      nbits = int'(size) * SW;
      mask = '0;
      for (b = 0; b < nbits; b++)
         mask[b] = 1'b1;
      // low lanes stay in place
      if (lsb)
         return data & mask;
      // top lanes go first and end up right aligned
      return data >> (PW - nbits);
   endfunction

   //##########################################################################
   // checks
   //##########################################################################

   task automatic abort_run(input string msg);
      $display("%s", msg);
      $display(">>> FAIL");
      $fatal(1, "simulation stopped on the first error");
   endtask

   task automatic check_word(input word_t got, input word_t exp, input string what);
      if (got !== exp)
         abort_run($sformatf("FAILED at %0t ns: %s is %h, expected %h",
                             $time, what, got, exp));
   endtask

   task automatic check_bit(input logic got, input logic exp, input string what);
      if (got !== exp)
         abort_run($sformatf("FAILED at %0t ns: %s is %b, expected %b",
                             $time, what, got, exp));
   endtask

   task automatic check_size(input size_t got, input size_t exp, input string what);
      if (got !== exp)
         abort_run($sformatf("FAILED at %0t ns: %s is %0d, expected %0d",
                             $time, what, got, exp));
   endtask

   // looks at the cycle that just ended, values read before the edge updates
   task automatic monitor_cycle();
      word_t exp_w;
      size_t exp_s;
      // a frame may not start right after a remote wait
      if (ser_link.valid && !prev_valid)
         check_bit(prev_wait, 1'b0, "link_wait in the cycle before a frame start");
      check_bit(link_busy, link_wait | ser_link.valid, "link_busy");
      if (ser_link.valid && ser_link.shift)
         strobes++;
      // frame end at the pins
      if (prev_valid && !ser_link.valid) begin
         if (exp_sizes.size() == 0) begin
            abort_run("a frame ended on ser_out while no push was pending");
         end
         else begin
            exp_s = exp_sizes.pop_front();
            check_size(size_t'(strobes), exp_s, "shift strobes in frame");
         end
         strobes = 0;
      end
      if (rx_valid) begin
         if (exp_words.size() == 0) begin
            abort_run("rx_valid pulsed while no word was expected");
         end
         else begin
            exp_w = exp_words.pop_front();
            check_word(rx_word, exp_w, "rx_word");
         end
      end
      prev_valid = ser_link.valid;
      prev_wait  = link_wait;
   endtask

   //##########################################################################
   // stimulus
   //##########################################################################

   task automatic drive_cycle(input logic allow_push, input logic burst);
      logic [31:0] bits;
      logic [31:0] data;
      tx_req_t     req;
      logic        go;
      take_bits(1, bits);
      shift_en <= bits[0];
      // about one cycle in five
      take_bits(4, bits);
      link_wait <= (bits[3:0] < 4'd3);
      // no push right after a push, so tx_full read here is up to date
      go = allow_push && (to_push > 0) && !tx_full && !tx_push;
      if (go && !burst) begin
         take_bits(5, bits);
         go = (bits[4:0] == 5'd0);
      end
      if (go) begin
         take_bits(32, data);
         take_bits(4, bits);
         req.data = data;
         req.size = size_t'(bits[3:0]) + 1'b1;
         // shortest and longest frame open every phase
         if (phase_pushes == 0)
            req.size = size_t'(1);
         else if (phase_pushes == 1)
            req.size = size_t'(NL);
         exp_words.push_back(expected_word(req.data, req.size, lsbfirst));
         exp_sizes.push_back(req.size);
         tx_req  <= req;
         tx_push <= 1'b1;
         to_push--;
         phase_pushes++;
      end
      else begin
         tx_push <= 1'b0;
      end
   endtask

   task automatic tick(input logic allow_push, input logic burst);
      @(posedge clk);
      monitor_cycle();
      drive_cycle(allow_push, burst);
   endtask

   task automatic run_phase(input int frames, input logic burst);
      logic saw_full;
      saw_full     = 1'b0;
      to_push      = frames;
      phase_pushes = 0;
      while (to_push > 0) begin
         tick(1'b1, burst);
         if (tx_full)
            saw_full = 1'b1;
      end
      if (burst)
         check_bit(saw_full, 1'b1, "tx_full during a push burst");
   endtask

   // every pushed word received, so queue, converter and collector are idle
   task automatic drain_link();
      while (exp_words.size() != 0)
         tick(1'b0, 1'b0);
   endtask

   task automatic set_order(input logic lsb);
      drain_link();
      lsbfirst <= lsb;
   endtask

   //##########################################################################
   // test sequence
   //##########################################################################

   initial begin
      clk          = 1'b0;
      nreset       = 1'b0;
      tx_push      = 1'b0;
      tx_req       = '0;
      lsbfirst     = 1'b0;
      shift_en     = 1'b0;
      link_wait    = 1'b0;
      lfsr_state   = LFSR_SEED;
      to_push      = 0;
      phase_pushes = 0;
      strobes      = 0;
      prev_valid   = 1'b0;
      prev_wait    = 1'b0;
      repeat (4) @(posedge clk);
      nreset <= 1'b1;
      // first cycle out of reset
      @(posedge clk);
      check_bit(ser_link.valid, 1'b0, "ser_out valid after reset");
      check_bit(rx_valid, 1'b0, "rx_valid after reset");
      check_bit(tx_full, 1'b0, "tx_full after reset");
      check_bit(link_busy, 1'b0, "link_busy after reset");
      // msb lane first, sparse then bursty
      run_phase(150, 1'b0);
      run_phase(100, 1'b1);
      // lsb lane first, switched while idle
      set_order(1'b1);
      run_phase(150, 1'b0);
      run_phase(100, 1'b1);
      drain_link();
      if (exp_words.size() == 0 && exp_sizes.size() == 0) begin
         $display(">>> PASS");
         $finish;
      end
      else begin
         abort_run("frames still expected at the end of the run");
      end
   end

   // watchdog
   initial begin
      #(WATCHDOG_NS);
      abort_run($sformatf("watchdog expired after %0d ns, the link stopped delivering words",
                          WATCHDOG_NS));
   end

endmodule

`default_nettype wire
